/* logic/soc_pkg.sv */
/*
  Shared definitions for the SoC bus fabric
  - bus, byte-select and interrupt widths
  - match/mask address windows, IO tag in the top bit
  - slave select enum and interrupt vector base
*/
package soc_pkg;

  localparam int ADR_W = 20;  // Tag bit plus 19 word address bits
  localparam int DAT_W = 16;
  localparam int SEL_W = 2;   // One select bit per byte lane
  localparam int IRQ_W = 8;

  // Boot ROM, mem 0xfff00 - 0xfffff
  localparam logic [ADR_W-1:0] ROM_MATCH  = 20'b0_1111_1111_1111_0000_000;
  localparam logic [ADR_W-1:0] ROM_MASK   = 20'b1_1111_1111_1111_0000_000;

  // Switches and LEDs, io 0xf100 - 0xf103
  localparam logic [ADR_W-1:0] GPIO_MATCH = 20'b1_0000_1111_0001_0000_000;
  localparam logic [ADR_W-1:0] GPIO_MASK  = 20'b1_0000_1111_1111_1111_110;

  // Base RAM takes every memory address left over
  localparam logic [ADR_W-1:0] RAM_MATCH  = 20'b0_0000_0000_0000_0000_000;
  localparam logic [ADR_W-1:0] RAM_MASK   = 20'b1_0000_0000_0000_0000_000;

  // Upper part of the vector returned on interrupt acknowledge
  localparam logic [DAT_W-1:0] VECTOR_BASE = 16'd8;

  typedef enum logic [1:0] {
    SLV_ROM,
    SLV_GPIO,
    SLV_RAM,
    SLV_DEFAULT  // Unmapped, answers at once with zero
  } slave_e;

endpackage

/* logic/reset_debounce.sv */
/*
  Reset debounce counter
  - holds rst_o for 2^DEBOUNCE_BITS cycles after rst_lck releases
*/
`timescale 1ns/1ps

module reset_debounce #(
  parameter int DEBOUNCE_BITS = 17
) (
  input  logic clk,
  input  logic rst_lck,
  output logic rst_o
);

  logic [DEBOUNCE_BITS-1:0] hold_cnt;

  // Any low glitch on the button reloads the full hold time
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      hold_cnt <= '1;
      rst_o    <= 1'b1;
    end else begin
      if (hold_cnt != '0)
        hold_cnt <= hold_cnt - 1'b1;
      rst_o <= (hold_cnt != '0);  // Falls one cycle after zero
    end
  end

endmodule

/* logic/bus_switch.sv */
/*
  Bus switch between the master port and the slaves
  - match/mask address decode, ROM then GPIO then RAM
  - per-slave strobe, read data and ack return path
  - default slave for unmapped accesses
*/
`timescale 1ns/1ps

module bus_switch (
  // Master side
  input  logic [soc_pkg::ADR_W-1:0] m_adr_i,
  input  logic                      m_cyc_i,
  input  logic                      m_stb_i,
  output logic [soc_pkg::DAT_W-1:0] m_dat_o,
  output logic                      m_ack_o,

  // Slave side
  output logic                      rom_stb_o,
  output logic                      ram_stb_o,
  output logic                      gpio_stb_o,
  input  logic [soc_pkg::DAT_W-1:0] rom_dat_i,
  input  logic                      rom_ack_i,
  input  logic [soc_pkg::DAT_W-1:0] ram_dat_i,
  input  logic                      ram_ack_i,
  input  logic [soc_pkg::DAT_W-1:0] gpio_dat_i,
  input  logic                      gpio_ack_i
);

  import soc_pkg::*;

  slave_e slv_sel;
  logic   bus_req;
  logic   def_ack;

  function automatic logic in_window(input logic [ADR_W-1:0] adr,
                                     input logic [ADR_W-1:0] match,
                                     input logic [ADR_W-1:0] mask);
    return (adr & mask) == match;
  endfunction

  // First matching window wins
  always_comb begin
    if (in_window(m_adr_i, ROM_MATCH, ROM_MASK))
      slv_sel = SLV_ROM;
    else if (in_window(m_adr_i, GPIO_MATCH, GPIO_MASK))
      slv_sel = SLV_GPIO;
    else if (in_window(m_adr_i, RAM_MATCH, RAM_MASK))
      slv_sel = SLV_RAM;
    else
      slv_sel = SLV_DEFAULT;
  end

  assign bus_req    = m_cyc_i & m_stb_i;
  assign rom_stb_o  = bus_req & (slv_sel == SLV_ROM);
  assign gpio_stb_o = bus_req & (slv_sel == SLV_GPIO);
  assign ram_stb_o  = bus_req & (slv_sel == SLV_RAM);
  assign def_ack    = bus_req & (slv_sel == SLV_DEFAULT);  // Writes dropped here

  always_comb begin
    case (slv_sel)
      SLV_ROM:  begin m_dat_o = rom_dat_i;  m_ack_o = rom_ack_i;  end
      SLV_GPIO: begin m_dat_o = gpio_dat_i; m_ack_o = gpio_ack_i; end
      SLV_RAM:  begin m_dat_o = ram_dat_i;  m_ack_o = ram_ack_i;  end
      default:  begin m_dat_o = '0;         m_ack_o = def_ack;    end
    endcase
  end

endmodule

/* logic/boot_rom.sv */
/*
  Boot ROM
  - sixteen words loaded from the boot image
  - registered read data and single-cycle ack
  - writes are acknowledged and ignored
*/
`timescale 1ns/1ps

module boot_rom (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stb_i,
  input  logic [3:0]                adr_i,
  output logic [soc_pkg::DAT_W-1:0] dat_o,
  output logic                      ack_o
);

  import soc_pkg::*;

  logic [DAT_W-1:0] rom_mem [16];

  initial $readmemh("logic/boot_image.hex", rom_mem);

  // Ack for one cycle, then low so the master can drop stb
  always_ff @(posedge clk) begin
    if (rst)
      ack_o <= 1'b0;
    else
      ack_o <= stb_i & ~ack_o;
  end

  always_ff @(posedge clk) begin
    dat_o <= rom_mem[adr_i];
  end

endmodule

/* logic/base_ram.sv */
/*
  Base RAM
  - word-addressed memory, aliased modulo its size
  - byte-lane writes through sel_i
  - registered read data and single-cycle ack
*/
`timescale 1ns/1ps

module base_ram #(
  parameter int RAM_ADDR_BITS = 10
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [soc_pkg::SEL_W-1:0] sel_i,
  input  logic [RAM_ADDR_BITS-1:0]  adr_i,
  input  logic [soc_pkg::DAT_W-1:0] dat_i,
  output logic [soc_pkg::DAT_W-1:0] dat_o,
  output logic                      ack_o
);

  import soc_pkg::*;

  logic [DAT_W-1:0] ram_mem [2**RAM_ADDR_BITS];

  always_ff @(posedge clk) begin
    if (rst)
      ack_o <= 1'b0;
    else
      ack_o <= stb_i & ~ack_o;
  end

  // Write once per access, on the cycle before ack
  always_ff @(posedge clk) begin
    if (stb_i && we_i && !ack_o) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (sel_i[b])
          ram_mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
      end
    end
    dat_o <= ram_mem[adr_i];  // Old word on a write cycle
  end

endmodule

/* logic/gpio_port.sv */
/*
  Switches and LEDs port
  - word 0 reads the sampled switches
  - word 1 reads and writes the LED register, low byte lane
*/
`timescale 1ns/1ps

module gpio_port (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [soc_pkg::SEL_W-1:0] sel_i,
  input  logic                      adr_i,
  input  logic [soc_pkg::DAT_W-1:0] dat_i,
  input  logic [7:0]                sw_i,
  output logic [soc_pkg::DAT_W-1:0] dat_o,
  output logic                      ack_o,
  output logic [7:0]                leds_o
);

  logic [7:0] sw_q;

  always_ff @(posedge clk) begin
    sw_q <= sw_i;  // One sampling stage
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_o  <= 1'b0;
      leds_o <= '0;
    end else begin
      ack_o <= stb_i & ~ack_o;
      if (stb_i && we_i && !ack_o && adr_i && sel_i[0])
        leds_o <= dat_i[7:0];
    end
  end

  always_ff @(posedge clk) begin
    dat_o <= adr_i ? {8'h00, leds_o} : {8'h00, sw_q};
  end

endmodule

/* logic/int_ctrl.sv */
/*
  Interrupt controller
  - rising-edge capture of the request lines into pending bits
  - fixed priority, line 0 highest
  - vector id latched and pending bit cleared on acknowledge
*/
`timescale 1ns/1ps

module int_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [soc_pkg::IRQ_W-1:0]         irq_i,
  input  logic                              inta_i,
  output logic                              intr_o,
  output logic [$clog2(soc_pkg::IRQ_W)-1:0] iid_o
);

  import soc_pkg::*;

  localparam int ID_W = $clog2(IRQ_W);

  logic [IRQ_W-1:0] irq_q;
  logic [IRQ_W-1:0] pending;
  logic [IRQ_W-1:0] clr_mask;
  logic [ID_W-1:0]  next_id;
  logic             inta_q;
  logic             inta_rise;

  // Lowest pending line wins
  always_comb begin
    next_id = '0;
    for (int i = IRQ_W - 1; i >= 0; i--) begin
      if (pending[i])
        next_id = ID_W'(i);
    end
  end

  // Acknowledge counts once, even with inta_i held through the read
  assign inta_rise = inta_i & ~inta_q;
  assign clr_mask  = inta_rise ? (IRQ_W'(1) << next_id) : '0;
  assign intr_o    = |pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      irq_q   <= '0;
      inta_q  <= 1'b0;
      pending <= '0;
      iid_o   <= '0;
    end else begin
      irq_q   <= irq_i;
      inta_q  <= inta_i;
      pending <= (pending & ~clr_mask) | (irq_i & ~irq_q);  // New edge wins
      if (inta_rise)
        iid_o <= next_id;
    end
  end

endmodule

/* logic/soc_fabric.sv */
/*
  SoC bus fabric top level
  - reset debounce, address switch and default slave
  - boot ROM, base RAM, switches/LEDs port, interrupt controller
  - interrupt vector merged into read data on acknowledge
*/
`timescale 1ns/1ps

module soc_fabric #(
  parameter int DEBOUNCE_BITS = 17,
  parameter int RAM_ADDR_BITS = 10
) (
  input  logic                      clk,
  input  logic                      rst_lck,
  input  logic [soc_pkg::ADR_W-1:0] m_adr_i,
  input  logic [soc_pkg::DAT_W-1:0] m_dat_i,
  input  logic [soc_pkg::SEL_W-1:0] m_sel_i,
  input  logic                      m_we_i,
  input  logic                      m_cyc_i,
  input  logic                      m_stb_i,
  output logic [soc_pkg::DAT_W-1:0] m_dat_o,
  output logic                      m_ack_o,
  input  logic                      inta_i,
  output logic                      intr_o,
  input  logic [soc_pkg::IRQ_W-1:0] irq_i,
  input  logic [7:0]                sw_i,
  output logic [7:0]                leds_o
);

  import soc_pkg::*;

  logic                       rst;
  logic [DAT_W-1:0]           sw_dat;
  logic                       rom_stb, ram_stb, gpio_stb;
  logic [DAT_W-1:0]           rom_dat, ram_dat, gpio_dat;
  logic                       rom_ack, ram_ack, gpio_ack;
  logic [$clog2(IRQ_W)-1:0]   iid;

  reset_debounce #(.DEBOUNCE_BITS(DEBOUNCE_BITS)) reset_debounce_i (
    .clk(clk), .rst_lck(rst_lck), .rst_o(rst)
  );

  bus_switch bus_switch_i (
    .m_adr_i(m_adr_i), .m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i),
    .m_dat_o(sw_dat), .m_ack_o(m_ack_o),
    .rom_stb_o(rom_stb), .ram_stb_o(ram_stb), .gpio_stb_o(gpio_stb),
    .rom_dat_i(rom_dat), .rom_ack_i(rom_ack),
    .ram_dat_i(ram_dat), .ram_ack_i(ram_ack),
    .gpio_dat_i(gpio_dat), .gpio_ack_i(gpio_ack)
  );

  boot_rom boot_rom_i (
    .clk(clk), .rst(rst), .stb_i(rom_stb), .adr_i(m_adr_i[3:0]),
    .dat_o(rom_dat), .ack_o(rom_ack)
  );

  base_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) base_ram_i (
    .clk(clk), .rst(rst), .stb_i(ram_stb), .we_i(m_we_i), .sel_i(m_sel_i),
    .adr_i(m_adr_i[RAM_ADDR_BITS-1:0]), .dat_i(m_dat_i),
    .dat_o(ram_dat), .ack_o(ram_ack)
  );

  gpio_port gpio_port_i (
    .clk(clk), .rst(rst), .stb_i(gpio_stb), .we_i(m_we_i), .sel_i(m_sel_i),
    .adr_i(m_adr_i[0]), .dat_i(m_dat_i), .sw_i(sw_i),
    .dat_o(gpio_dat), .ack_o(gpio_ack), .leds_o(leds_o)
  );

  int_ctrl int_ctrl_i (
    .clk(clk), .rst(rst), .irq_i(irq_i), .inta_i(inta_i),
    .intr_o(intr_o), .iid_o(iid)
  );

  // Acknowledge read returns the vector instead of bus data
  assign m_dat_o = (inta_i & m_cyc_i & m_stb_i) ? VECTOR_BASE + DAT_W'(iid) : sw_dat;

endmodule

/* verification/tb_soc_fabric.sv */
/*
  Testbench for the SoC bus fabric
  - clock, reset and bus master tasks
  - operations read from the test data file, RAM byte-lane model
  - value check task and hang watchdog
*/
`timescale 1ns/1ps

module tb_soc_fabric;

  import soc_pkg::*;

  localparam int DEB_BITS   = 3;
  localparam int RST_CYCLES = 3;
  localparam int MAX_OPS    = 64;
  localparam int RAM_BITS   = 10;  // Alias test writes 0x410 onto 0x010
  localparam int RAM_WORDS  = 2**RAM_BITS;

  logic             clk;
  logic             rst_lck;
  logic [ADR_W-1:0] m_adr;
  logic [DAT_W-1:0] m_wdat;
  logic [SEL_W-1:0] m_sel;
  logic             m_we;
  logic             m_cyc;
  logic             m_stb;
  logic [DAT_W-1:0] m_rdat;
  logic             m_ack;
  logic             inta;
  logic             intr;
  logic [IRQ_W-1:0] irq;
  logic [7:0]       sw;
  logic [7:0]       leds;

  logic [63:0]      ops [MAX_OPS];
  logic [DAT_W-1:0] ram_model [RAM_WORDS];
  int               n_ops = 0;

  soc_fabric #(
    .DEBOUNCE_BITS(DEB_BITS),
    .RAM_ADDR_BITS(RAM_BITS)
  ) soc_fabric_i (
    .clk(clk), .rst_lck(rst_lck),
    .m_adr_i(m_adr), .m_dat_i(m_wdat), .m_sel_i(m_sel), .m_we_i(m_we),
    .m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_dat_o(m_rdat), .m_ack_o(m_ack),
    .inta_i(inta), .intr_o(intr), .irq_i(irq), .sw_i(sw), .leds_o(leds)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string test_name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // One handshake with ack sampled mid-cycle where it is stable
  task automatic bus_access(input string test_name, input logic [ADR_W-1:0] adr,
                            input logic we, input logic [SEL_W-1:0] sel,
                            input logic [DAT_W-1:0] wdat, input logic [3:0] lat_exp,
                            output logic [DAT_W-1:0] rdat);
    int lat;
    lat = 0;
    @(posedge clk);
    #2;
    m_adr = adr;
    m_we  = we;
    m_sel = sel;
    m_wdat = wdat;
    m_cyc = 1'b1;
    m_stb = 1'b1;
    @(negedge clk);
    while (!m_ack) begin
      lat++;  // Edges passed without ack
      @(negedge clk);
    end
    rdat = m_rdat;
    @(posedge clk);
    #2;
    m_cyc = 1'b0;
    m_stb = 1'b0;
    m_we  = 1'b0;
    check_value({test_name, " ack latency"}, 16'(lat_exp), 16'(lat));
  endtask

  function automatic void model_write(input logic [ADR_W-1:0] adr,
                                      input logic [SEL_W-1:0] sel,
                                      input logic [DAT_W-1:0] dat);
    if (sel[0])
      ram_model[adr[RAM_BITS-1:0]][7:0] = dat[7:0];
    if (sel[1])
      ram_model[adr[RAM_BITS-1:0]][15:8] = dat[15:8];
  endfunction

  initial begin
    logic [63:0]      op_line;
    logic [3:0]       op;
    logic [3:0]       lat_exp;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] wdat;
    logic [DAT_W-1:0] exp_val;
    logic [DAT_W-1:0] rdat;
    string            name;

    clk     = 1'b0;
    rst_lck = 1'b0;
    m_adr   = '0;
    m_wdat  = '0;
    m_sel   = '0;
    m_we    = 1'b0;
    m_cyc   = 1'b0;
    m_stb   = 1'b0;
    inta    = 1'b0;
    irq     = '0;
    sw      = '0;
    void'($urandom(32'h3c7d));
    for (int i = 0; i < MAX_OPS; i++)
      ops[i] = '0;
    for (int i = 0; i < RAM_WORDS; i++)
      ram_model[i] = '0;
    $readmemh("verification/soc_fabric_testdata.txt", ops);
    while (n_ops < MAX_OPS && ops[n_ops][63:60] != 4'h0)
      n_ops++;
    if (n_ops == 0) begin
      $display("No operations found in the test data file");
      $display("Simulation failed");
      $fatal(1, "empty test data");
    end

    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst_lck = 1'b1;
    repeat (2**DEB_BITS + 4) @(posedge clk);  // Debounce hold time
    @(negedge clk);
    check_value("reset ack", 16'd0, 16'(m_ack));
    check_value("reset intr", 16'd0, 16'(intr));
    check_value("reset leds", 16'd0, 16'(leds));

    for (int i = 0; i < n_ops; i++) begin
      op_line = ops[i];
      op      = op_line[63:60];
      lat_exp = op_line[59:56];
      adr     = op_line[51:32];
      wdat    = op_line[31:16];
      exp_val = op_line[15:0];
      name    = $sformatf("data line %0d op %h", i, op);
      case (op)
        4'h1: begin
          bus_access(name, adr, 1'b0, op_line[53:52], '0, lat_exp, rdat);
          check_value(name, exp_val, rdat);
        end
        4'h2, 4'h4: begin
          if (op == 4'h4)
            wdat = 16'($urandom);
          bus_access(name, adr, 1'b1, op_line[53:52], wdat, lat_exp, rdat);
          model_write(adr, op_line[53:52], wdat);
        end
        4'h3: bus_access(name, adr, 1'b1, op_line[53:52], wdat, lat_exp, rdat);
        4'h5: begin
          bus_access(name, adr, 1'b0, op_line[53:52], '0, lat_exp, rdat);
          check_value(name, ram_model[adr[RAM_BITS-1:0]], rdat);
        end
        4'h6: begin
          @(posedge clk);
          #2;
          sw = 8'($urandom);
          @(posedge clk);  // Switch sampling stage
          bus_access(name, adr, 1'b0, op_line[53:52], '0, lat_exp, rdat);
          check_value(name, {8'h00, sw}, rdat);
        end
        4'h7: begin
          @(negedge clk);
          check_value(name, exp_val, 16'(leds));
        end
        4'h8: begin
          @(posedge clk);
          #2;
          irq = irq | wdat[IRQ_W-1:0];
          @(posedge clk);
          @(negedge clk);
          check_value(name, exp_val, 16'(intr));
        end
        4'h9: begin
          @(posedge clk);
          #2;
          inta = 1'b1;  // Id latched at the next edge before the vector read
          bus_access(name, adr, 1'b0, op_line[53:52], '0, lat_exp, rdat);
          inta = 1'b0;
          check_value(name, exp_val, rdat);
        end
        4'hA: begin
          @(negedge clk);
          check_value(name, exp_val, 16'(intr));
        end
        default: begin
          $display("Unknown operation code %h on data line %0d", op, i);
          $display("Simulation failed");
          $fatal(1, "bad test data");
        end
      endcase
    end

    $display("Simulation completed successfully");
    $finish;
  end

  // Generous bound per operation plus the reset time
  initial begin
    wait (n_ops > 0);
    repeat (RST_CYCLES + 2**DEB_BITS + 4 + 50 * n_ops) @(posedge clk);
    $display("Timeout: the run did not end within the cycle limit for %0d operations",
             n_ops);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* soc_fabric.f */
logic/soc_pkg.sv
logic/reset_debounce.sv
logic/bus_switch.sv
logic/boot_rom.sv
logic/base_ram.sv
logic/gpio_port.sv
logic/int_ctrl.sv
logic/soc_fabric.sv
verification/tb_soc_fabric.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_soc_fabric
FILELIST  = soc_fabric.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/boot_image.hex */
e9fd
00fc
33c0
8ed8
8ed0
bc00
7c00
fbfc
b800
f000
8ec0
eb00
9090
9090
90ea
00f0

/* verification/soc_fabric_testdata.txt */
// Columns op_lat_sel_adr_wdat_exp in hex, lat is the expected ack latency in cycles
// op 1 read, 2 RAM write, 3 other write, 4 RAM random write, 5 RAM read vs model,
// op 6 switch read, 7 LEDs, 8 raise irq, 9 interrupt acknowledge, a intr level
1_1_3_7ff80_0000_e9fd  // Boot word 0
1_1_3_7ffff_0000_00f0
3_1_3_7ff85_1234_0000  // ROM write is dropped
1_1_3_7ff85_0000_bc00
2_1_3_00010_a5c3_0000
1_1_3_00010_0000_a5c3
2_1_1_00010_0077_0000  // Low byte lane
1_1_3_00010_0000_a577
2_1_2_00010_be00_0000  // High byte lane
1_1_3_00010_0000_be77
2_1_3_00410_1111_0000  // Aliases word 0x010
1_1_3_00010_0000_1111
4_1_3_00020_0000_0000
4_1_1_00020_0000_0000
5_1_3_00020_0000_0000
6_1_3_87880_0000_0000
3_1_1_87881_005a_0000
7_0_0_00000_0000_005a
1_1_3_87881_0000_005a
1_0_3_80010_0000_0000  // Unmapped IO, same-cycle ack
3_0_3_80010_beef_0000
8_0_0_00000_0016_0001  // Lines 1, 2 and 4
9_0_3_80040_0000_0009
9_0_3_80040_0000_000a
a_0_0_00000_0000_0001
9_0_3_80040_0000_000c
a_0_0_00000_0000_0000
